// ==== exec_pkg.sv ====
package exec_pkg;

	typedef logic [31:0] word_t;

	typedef logic [4:0] shamt_t;

	typedef enum logic [4:0] {
		// bitwise logic
		op_or, op_and, op_nor, op_xor,
		// shifts, amount in a[4:0]
		op_sll, op_srl, op_sra,
		// adder based and bit counts
		op_add, op_addu, op_sub, op_subu,
		op_slt, op_sltu, op_clz, op_clo,
		// 64 bit products into hi/lo
		op_mult, op_multu, op_madd, op_maddu, op_msub, op_msubu,
		// hi/lo moves
		op_mfhi, op_mflo, op_mthi, op_mtlo
	} exec_op_e;

	// which block supplies the result
	typedef enum logic [2:0] {
		cls_logic_shift,
		cls_arith,
		cls_mul,
		cls_hilo_read,
		cls_hilo_write
	} op_class_e;

	function automatic op_class_e op_class(input exec_op_e op);
		op_class_e cls;
		case (op)
			op_or, op_and, op_nor, op_xor, op_sll, op_srl, op_sra: cls = cls_logic_shift;
			op_mult, op_multu, op_madd, op_maddu, op_msub, op_msubu: cls = cls_mul;
			op_mfhi, op_mflo: cls = cls_hilo_read;
			op_mthi, op_mtlo: cls = cls_hilo_write;
			default: cls = cls_arith;
		endcase
		return cls;
	endfunction

	typedef struct packed {
		exec_op_e op;
		word_t    a;
		word_t    b;
	} exec_req_t;

	typedef struct packed {
		word_t result;
		logic  write_en;
		logic  overflow;
	} exec_rsp_t;

	typedef struct packed {
		word_t hi;
		word_t lo;
	} hilo_pair_t;

	// accumulation sees one 64 bit number, the moves see two halves
	typedef union packed {
		logic [63:0] full;
		hilo_pair_t  pair;
	} hilo_u;

endpackage

// ==== logic_shift_unit.sv ====
module logic_shift_unit (
	input  exec_pkg::exec_op_e op_i,
	input  exec_pkg::word_t    a_i,
	input  exec_pkg::word_t    b_i,
	output exec_pkg::word_t    result_o
);

	exec_pkg::shamt_t shamt;

	// shift amount comes from the low bits of a, the value from b
	assign shamt = a_i[4:0];

	always_comb begin
		case (op_i)
			exec_pkg::op_or: begin
				result_o = a_i | b_i;
			end
			exec_pkg::op_and: begin
				result_o = a_i & b_i;
			end
			exec_pkg::op_nor: begin
				result_o = ~(a_i | b_i);
			end
			exec_pkg::op_xor: begin
				result_o = a_i ^ b_i;
			end
			exec_pkg::op_sll: begin
				result_o = b_i << shamt;
			end
			exec_pkg::op_srl: begin
				result_o = b_i >> shamt;
			end
			exec_pkg::op_sra: begin
				result_o = exec_pkg::word_t'($signed(b_i) >>> shamt);
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// ==== arith_unit.sv ====
module arith_unit (
	input  exec_pkg::exec_op_e op_i,
	input  exec_pkg::word_t    a_i,
	input  exec_pkg::word_t    b_i,
	output exec_pkg::word_t    result_o,
	output logic               ovf_o
);

	logic            invert_b;
	exec_pkg::word_t b_op;
	logic [32:0]     sum;
	logic            ovf_raw;
	logic            lt_signed;
	logic            lt_unsigned;
	exec_pkg::word_t lead_cnt;

	function automatic exec_pkg::word_t count_lz(input exec_pkg::word_t x);
		exec_pkg::word_t n;
		n = 32'd32;
		// last hit is the highest set bit
		for (int i = 0; i < 32; i++) begin
			if (x[i]) begin
				n = exec_pkg::word_t'(31 - i);
			end
		end
		return n;
	endfunction

	assign invert_b = op_i inside {exec_pkg::op_sub, exec_pkg::op_subu,
	                               exec_pkg::op_slt, exec_pkg::op_sltu};

	// a - b done as a + ~b + 1
	assign b_op = invert_b ? ~b_i : b_i;
	assign sum  = {1'b0, a_i} + {1'b0, b_op} + {32'd0, invert_b};

	assign ovf_raw = (a_i[31] == b_op[31]) && (sum[31] != a_i[31]);

	assign lt_signed   = (a_i[31] && !b_i[31]) || ((a_i[31] == b_i[31]) && sum[31]);
	// no carry out means a borrow
	assign lt_unsigned = !sum[32];

	assign lead_cnt = count_lz((op_i == exec_pkg::op_clo) ? ~a_i : a_i);

	assign ovf_o = (op_i == exec_pkg::op_add || op_i == exec_pkg::op_sub) && ovf_raw;

	always_comb begin
		case (op_i)
			exec_pkg::op_add, exec_pkg::op_addu, exec_pkg::op_sub, exec_pkg::op_subu: begin
				result_o = sum[31:0];
			end
			exec_pkg::op_slt: begin
				result_o = {31'd0, lt_signed};
			end
			exec_pkg::op_sltu: begin
				result_o = {31'd0, lt_unsigned};
			end
			exec_pkg::op_clz, exec_pkg::op_clo: begin
				result_o = lead_cnt;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// ==== mul_acc_unit.sv ====
module mul_acc_unit #(
	parameter int mul_latency = 2
) (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               start_i,
	input  exec_pkg::exec_op_e op_i,
	input  exec_pkg::word_t    a_i,
	input  exec_pkg::word_t    b_i,
	input  exec_pkg::hilo_u    hilo_i,
	output logic               done_o,
	output exec_pkg::hilo_u    result_o
);

	typedef struct packed {
		logic        neg;
		logic        acc;
		logic        sub;
		logic [63:0] mag;
	} mul_stage_t;

	logic                   is_signed;
	exec_pkg::word_t        a_mag;
	exec_pkg::word_t        b_mag;
	mul_stage_t             stage_d;
	mul_stage_t             stage_q [mul_latency];
	logic [mul_latency-1:0] vld_q;
	mul_stage_t             last;
	logic                   last_vld;
	logic [63:0]            product;
	exec_pkg::hilo_u        acc_q;
	logic                   acc_vld_q;

	assign is_signed = op_i inside {exec_pkg::op_mult, exec_pkg::op_madd, exec_pkg::op_msub};

	// magnitudes multiply unsigned and the sign is fixed at the end
	assign a_mag = (is_signed && a_i[31]) ? -a_i : a_i;
	assign b_mag = (is_signed && b_i[31]) ? -b_i : b_i;

	assign stage_d.neg = is_signed && (a_i[31] ^ b_i[31]);
	assign stage_d.acc = op_i inside {exec_pkg::op_madd, exec_pkg::op_maddu,
	                                  exec_pkg::op_msub, exec_pkg::op_msubu};
	assign stage_d.sub = op_i inside {exec_pkg::op_msub, exec_pkg::op_msubu};
	assign stage_d.mag = {32'd0, a_mag} * {32'd0, b_mag};

	assign last     = stage_q[mul_latency-1];
	assign last_vld = vld_q[mul_latency-1];
	assign product  = last.neg ? -last.mag : last.mag;

	always_ff @(posedge clk) begin
		stage_q[0] <= stage_d;
		for (int i = 1; i < mul_latency; i++) begin
			stage_q[i] <= stage_q[i-1];
		end
		acc_q.full <= last.sub ? hilo_i.full - product : hilo_i.full + product;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			vld_q     <= '0;
			acc_vld_q <= 1'b0;
		end else begin
			vld_q[0] <= start_i;
			for (int i = 1; i < mul_latency; i++) begin
				vld_q[i] <= vld_q[i-1];
			end
			acc_vld_q <= last_vld && last.acc;
		end
	end

	// plain products finish at the pipe end, madd/msub one step later
	assign done_o = (last_vld && !last.acc) || acc_vld_q;

	always_comb begin
		result_o.full = acc_vld_q ? acc_q.full : product;
	end

endmodule

// ==== hilo_regs.sv ====
module hilo_regs (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            we_i,
	input  exec_pkg::hilo_u hilo_i,
	output exec_pkg::hilo_u hilo_o
);

	exec_pkg::hilo_u hilo_q;

	// architectural hi/lo state
	always_ff @(posedge clk) begin
		if (reset_i) begin
			hilo_q.full <= '0;
		end else if (we_i) begin
			hilo_q <= hilo_i;
		end
	end

	// read by mfhi/mflo, mthi/mtlo and the accumulator
	assign hilo_o = hilo_q;

endmodule

// ==== exec_ctrl.sv ====
module exec_ctrl #(
	parameter int mul_latency = 2
) (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                req_i,
	input  exec_pkg::exec_req_t req_data_i,
	output logic                ack_o,
	output exec_pkg::exec_rsp_t rsp_o,
	output exec_pkg::exec_op_e  op_o,
	output exec_pkg::word_t     a_o,
	output exec_pkg::word_t     b_o,
	input  exec_pkg::word_t     ls_result_i,
	input  exec_pkg::word_t     arith_result_i,
	input  logic                arith_ovf_i,
	output logic                mul_start_o,
	input  logic                mul_done_i,
	input  exec_pkg::hilo_u     mul_result_i,
	input  exec_pkg::hilo_u     hilo_i,
	output logic                hilo_we_o,
	output exec_pkg::hilo_u     hilo_o
);

	// watchdog bound above the longest legal wait of mul_latency + 1
	localparam int wd_limit = mul_latency + 4;
	localparam int wd_w = $clog2(wd_limit + 1);

	typedef enum logic [2:0] {
		st_idle,
		st_busy,
		st_wait_mul,
		st_ack,
		st_wait_release
	} state_e;

	state_e               state_q;
	exec_pkg::exec_req_t  req_q;
	exec_pkg::exec_rsp_t  rsp_q;
	exec_pkg::exec_rsp_t  rsp_d;
	exec_pkg::op_class_e  cls;
	logic [wd_w-1:0]      wd_cnt_q;

	assign cls = exec_pkg::op_class(req_q.op);

	assign op_o = req_q.op;
	assign a_o  = req_q.a;
	assign b_o  = req_q.b;

	assign ack_o = (state_q == st_ack) || (state_q == st_wait_release);
	assign rsp_o = rsp_q;

	assign mul_start_o = (state_q == st_busy) && (cls == exec_pkg::cls_mul);
	assign hilo_we_o   = ((state_q == st_busy) && (cls == exec_pkg::cls_hilo_write)) ||
	                     ((state_q == st_wait_mul) && mul_done_i);

	always_comb begin
		rsp_d = '0;
		case (cls)
			exec_pkg::cls_logic_shift: begin
				rsp_d.result   = ls_result_i;
				rsp_d.write_en = 1'b1;
			end
			exec_pkg::cls_arith: begin
				rsp_d.result   = arith_result_i;
				// overflowing add/sub must not reach the register file
				rsp_d.write_en = !arith_ovf_i;
				rsp_d.overflow = arith_ovf_i;
			end
			exec_pkg::cls_hilo_read: begin
				rsp_d.result   = (req_q.op == exec_pkg::op_mfhi) ? hilo_i.pair.hi : hilo_i.pair.lo;
				rsp_d.write_en = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// mthi/mtlo keep the other half
	always_comb begin
		hilo_o = mul_result_i;
		if (cls == exec_pkg::cls_hilo_write) begin
			hilo_o = hilo_i;
			if (req_q.op == exec_pkg::op_mthi) begin
				hilo_o.pair.hi = req_q.a;
			end else begin
				hilo_o.pair.lo = req_q.a;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle && req_i) begin
			req_q <= req_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q  <= st_idle;
			rsp_q    <= '0;
			wd_cnt_q <= '0;
		end else begin
			case (state_q)
				st_idle: begin
					if (req_i) begin
						state_q <= st_busy;
					end
				end
				st_busy: begin
					wd_cnt_q <= '0;
					if (cls == exec_pkg::cls_mul) begin
						state_q <= st_wait_mul;
					end else begin
						rsp_q   <= rsp_d;
						state_q <= st_ack;
					end
				end
				st_wait_mul: begin
					wd_cnt_q <= wd_cnt_q + 1'b1;
					// products only go to hi/lo, so the answer is zero either way
					if (mul_done_i || wd_cnt_q == wd_w'(wd_limit)) begin
						rsp_q   <= '0;
						state_q <= st_ack;
					end
				end
				st_ack: begin
					state_q <= req_i ? st_wait_release : st_idle;
				end
				default: begin
					if (!req_i) begin
						state_q <= st_idle;
					end
				end
			endcase
		end
	end

endmodule

// ==== exec_unit.sv ====
module exec_unit #(
	parameter int mul_latency = 2
) (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                req_i,
	input  exec_pkg::exec_req_t req_data_i,
	output logic                ack_o,
	output exec_pkg::exec_rsp_t rsp_o
);

	exec_pkg::exec_op_e op;
	exec_pkg::word_t    a;
	exec_pkg::word_t    b;
	exec_pkg::word_t    ls_result;
	exec_pkg::word_t    arith_result;
	logic               arith_ovf;
	logic               mul_start;
	logic               mul_done;
	exec_pkg::hilo_u    mul_result;
	exec_pkg::hilo_u    hilo_cur;
	exec_pkg::hilo_u    hilo_new;
	logic               hilo_we;

	exec_ctrl #(
		.mul_latency(mul_latency)
	) u_ctrl (
		.clk           (clk),
		.reset_i       (reset_i),
		.req_i         (req_i),
		.req_data_i    (req_data_i),
		.ack_o         (ack_o),
		.rsp_o         (rsp_o),
		.op_o          (op),
		.a_o           (a),
		.b_o           (b),
		.ls_result_i   (ls_result),
		.arith_result_i(arith_result),
		.arith_ovf_i   (arith_ovf),
		.mul_start_o   (mul_start),
		.mul_done_i    (mul_done),
		.mul_result_i  (mul_result),
		.hilo_i        (hilo_cur),
		.hilo_we_o     (hilo_we),
		.hilo_o        (hilo_new)
	);

	logic_shift_unit u_logic_shift (
		.op_i    (op),
		.a_i     (a),
		.b_i     (b),
		.result_o(ls_result)
	);

	arith_unit u_arith (
		.op_i    (op),
		.a_i     (a),
		.b_i     (b),
		.result_o(arith_result),
		.ovf_o   (arith_ovf)
	);

	mul_acc_unit #(
		.mul_latency(mul_latency)
	) u_mul_acc (
		.clk     (clk),
		.reset_i (reset_i),
		.start_i (mul_start),
		.op_i    (op),
		.a_i     (a),
		.b_i     (b),
		.hilo_i  (hilo_cur),
		.done_o  (mul_done),
		.result_o(mul_result)
	);

	hilo_regs u_hilo (
		.clk    (clk),
		.reset_i(reset_i),
		.we_i   (hilo_we),
		.hilo_i (hilo_new),
		.hilo_o (hilo_cur)
	);

endmodule

// ==== exec_unit_properties.sv ====
module exec_unit_properties (
	input logic                clk,
	input logic                reset_i,
	input logic                req_i,
	input logic                ack_i,
	input exec_pkg::exec_rsp_t rsp_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// also covers the first cycle out of reset
	ack_low_in_reset: assert property (@(posedge clk) reset_i |=> !ack_i)
		else $error("ack_o high during or right after reset");

	ack_rise_needs_req: assert property (@(posedge clk) disable iff (reset_i)
		$rose(ack_i) |-> $past(req_i))
		else $error("ack_o rose without a pending request");

	rsp_held_during_ack: assert property (@(posedge clk) disable iff (reset_i)
		ack_i |=> (!ack_i || $stable(rsp_i)))
		else $error("rsp_o changed while ack_o was high");

	ack_falls_after_release: assert property (@(posedge clk) disable iff (reset_i)
		(ack_i && !req_i) |=> !ack_i)
		else $error("ack_o did not fall one cycle after req_i went low");

	// back-pressure keeps the answer up
	ack_held_while_req: assert property (@(posedge clk) disable iff (reset_i)
		(ack_i && req_i) |=> ack_i)
		else $error("ack_o dropped while req_i was still high");

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever begin
			#10;
			clk_o = ~clk_o;
		end
	end

	// reset over the first 8 rising edges
	initial begin
		reset_o = 1'b1;
		repeat (8) begin
			@(posedge clk_o);
		end
		#2;
		reset_o = 1'b0;
	end

endmodule

// ==== tb_exec_unit.sv ====
module tb_exec_unit;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int wait_limit = 20;

	logic                clk;
	logic                reset;
	logic                req;
	exec_pkg::exec_req_t req_data;
	logic                ack;
	exec_pkg::exec_rsp_t rsp;
	logic [63:0]         model_hilo;
	logic [31:0]         rng;

	exec_pkg::exec_op_e logic_ops [7] = '{exec_pkg::op_or, exec_pkg::op_and, exec_pkg::op_nor,
		exec_pkg::op_xor, exec_pkg::op_sll, exec_pkg::op_srl, exec_pkg::op_sra};
	exec_pkg::exec_op_e arith_ops [8] = '{exec_pkg::op_addu, exec_pkg::op_subu,
		exec_pkg::op_slt, exec_pkg::op_sltu, exec_pkg::op_clz, exec_pkg::op_clo,
		exec_pkg::op_add, exec_pkg::op_sub};
	exec_pkg::exec_op_e acc_ops [4] = '{exec_pkg::op_madd, exec_pkg::op_maddu,
		exec_pkg::op_msub, exec_pkg::op_msubu};
	exec_pkg::word_t corner_vals [5] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
		32'h7fff_ffff, 32'h0000_0001};

	tb_clock_gen u_clock (
		.clk_o  (clk),
		.reset_o(reset)
	);

	exec_unit #(
		.mul_latency(2)
	) dut0 (
		.clk       (clk),
		.reset_i   (reset),
		.req_i     (req),
		.req_data_i(req_data),
		.ack_o     (ack),
		.rsp_o     (rsp)
	);

	bind exec_unit exec_unit_properties u_props (
		.clk    (clk),
		.reset_i(reset_i),
		.req_i  (req_i),
		.ack_i  (ack_o),
		.rsp_i  (rsp_o)
	);

	function automatic exec_pkg::word_t xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic exec_pkg::word_t lead_count(input exec_pkg::word_t x, input logic bit_val);
		int n;
		n = 0;
		while (n < 32 && x[31 - n] == bit_val) begin
			n++;
		end
		return exec_pkg::word_t'(n);
	endfunction

	// predicts the response from the instruction rules and steps the model hi/lo
	function automatic void predict(input exec_pkg::exec_op_e op, input exec_pkg::word_t a,
			input exec_pkg::word_t b, output exec_pkg::exec_rsp_t exp);
		logic [4:0]  sh;
		longint      s;
		logic [63:0] prod;
		sh = a[4:0];
		exp = '0;
		exp.write_en = 1'b1;
		case (op)
			exec_pkg::op_or: exp.result = a | b;
			exec_pkg::op_and: exp.result = a & b;
			exec_pkg::op_nor: exp.result = ~(a | b);
			exec_pkg::op_xor: exp.result = a ^ b;
			exec_pkg::op_sll: exp.result = b << sh;
			exec_pkg::op_srl: exp.result = b >> sh;
			exec_pkg::op_sra: exp.result = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			exec_pkg::op_addu: exp.result = a + b;
			exec_pkg::op_subu: exp.result = a - b;
			exec_pkg::op_slt: exp.result = {31'd0, $signed(a) < $signed(b)};
			exec_pkg::op_sltu: exp.result = {31'd0, a < b};
			exec_pkg::op_clz: exp.result = lead_count(a, 1'b0);
			exec_pkg::op_clo: exp.result = lead_count(a, 1'b1);
			exec_pkg::op_add, exec_pkg::op_sub: begin
				s = longint'($signed(a));
				s = (op == exec_pkg::op_add) ? s + longint'($signed(b)) : s - longint'($signed(b));
				exp.result   = s[31:0];
				// true result does not fit in 32 signed bits
				exp.overflow = s[32] != s[31];
				exp.write_en = !exp.overflow;
			end
			exec_pkg::op_mfhi: exp.result = model_hilo[63:32];
			exec_pkg::op_mflo: exp.result = model_hilo[31:0];
			exec_pkg::op_mthi: begin
				model_hilo[63:32] = a;
				exp.write_en = 1'b0;
			end
			exec_pkg::op_mtlo: begin
				model_hilo[31:0] = a;
				exp.write_en = 1'b0;
			end
			default: begin
				if (op inside {exec_pkg::op_mult, exec_pkg::op_madd, exec_pkg::op_msub}) begin
					prod = longint'($signed(a)) * longint'($signed(b));
				end else begin
					prod = {32'd0, a} * {32'd0, b};
				end
				if (op inside {exec_pkg::op_mult, exec_pkg::op_multu}) begin
					model_hilo = prod;
				end else if (op inside {exec_pkg::op_madd, exec_pkg::op_maddu}) begin
					model_hilo = model_hilo + prod;
				end else begin
					model_hilo = model_hilo - prod;
				end
				exp.write_en = 1'b0;
			end
		endcase
	endfunction

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input exec_pkg::word_t got,
			input exec_pkg::word_t exp);
		assert (got === exp) else begin
			$display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (reset !== 1'b0 && n < 4 * wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (reset !== 1'b0) begin
			$display("timeout: reset was never released");
			abort_run();
		end
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (ack !== level && n < wait_limit) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (ack !== level) begin
			$display("timeout: ack_o did not go %s within %0d cycles", level ? "high" : "low",
				wait_limit);
			abort_run();
		end
	endtask

	// one four-phase transfer with req held for hold extra cycles after ack
	task automatic transact(input exec_pkg::exec_op_e op, input exec_pkg::word_t a,
			input exec_pkg::word_t b, input int hold, output exec_pkg::exec_rsp_t got);
		req_data.op = op;
		req_data.a  = a;
		req_data.b  = b;
		req = 1'b1;
		wait_ack(1'b1);
		got = rsp;
		repeat (hold) begin
			@(posedge clk);
			#2;
		end
		req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic run_check(input exec_pkg::exec_op_e op, input exec_pkg::word_t a,
			input exec_pkg::word_t b, input int hold);
		exec_pkg::exec_rsp_t exp;
		exec_pkg::exec_rsp_t got;
		predict(op, a, b, exp);
		transact(op, a, b, hold, got);
		check_word($sformatf("rsp_o.result (%s)", op.name()), got.result, exp.result);
		check_word($sformatf("rsp_o.write_en (%s)", op.name()),
			exec_pkg::word_t'(got.write_en), exec_pkg::word_t'(exp.write_en));
		check_word($sformatf("rsp_o.overflow (%s)", op.name()),
			exec_pkg::word_t'(got.overflow), exec_pkg::word_t'(exp.overflow));
	endtask

	task automatic read_hilo();
		run_check(exec_pkg::op_mfhi, xorshift(), '0, 0);
		run_check(exec_pkg::op_mflo, xorshift(), '0, 0);
	endtask

	initial begin
		exec_pkg::word_t x;
		exec_pkg::word_t y;
		req = 1'b0;
		req_data = '0;
		model_hilo = '0;
		rng = 32'd13;
		wait_reset_release();
		@(posedge clk);
		#2;

		foreach (logic_ops[k]) begin
			for (int i = 0; i < 10; i++) begin
				x = xorshift();
				y = xorshift();
				run_check(logic_ops[k], x, y, (i % 4 == 3) ? 3 : 0);
			end
		end

		// random pairs, then every pair of corner values
		foreach (arith_ops[k]) begin
			for (int i = 0; i < 10; i++) begin
				x = xorshift();
				y = xorshift();
				run_check(arith_ops[k], x, y, 0);
			end
			foreach (corner_vals[i]) begin
				foreach (corner_vals[j]) begin
					run_check(arith_ops[k], corner_vals[i], corner_vals[j], (j == 2) ? 2 : 0);
				end
			end
		end

		for (int i = 0; i < 12; i++) begin
			x = xorshift();
			y = xorshift();
			if (i >= 6) begin
				x = x | 32'h8000_0000;
			end
			if (i >= 9) begin
				y = y | 32'h8000_0000;
			end
			run_check((i % 2 == 0) ? exec_pkg::op_mult : exec_pkg::op_multu, x, y,
				(i == 5) ? 4 : 0);
			read_hilo();
		end

		// accumulate chains on a freshly loaded hi/lo
		foreach (acc_ops[k]) begin
			run_check(exec_pkg::op_mthi, xorshift(), '0, 0);
			read_hilo();
			run_check(exec_pkg::op_mtlo, xorshift(), '0, 0);
			read_hilo();
			for (int i = 0; i < 4; i++) begin
				x = xorshift();
				y = xorshift();
				if (i == 1) begin
					x = x | 32'h8000_0000;
				end
				run_check(acc_ops[k], x, y, (i == 2) ? 3 : 0);
				read_hilo();
			end
		end

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== exec_unit.f ====
exec_pkg.sv
logic_shift_unit.sv
arith_unit.sv
mul_acc_unit.sv
hilo_regs.sv
exec_ctrl.sv
exec_unit.sv
exec_unit_properties.sv
tb_clock_gen.sv
tb_exec_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_exec_unit -f exec_unit.f -o sim_exec_unit

output=$(./obj_dir/sim_exec_unit 2>&1 || true)
echo "$output"
echo "$output" | grep -q "All tests passed"
